// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f vlog.f --top-module cpuTb -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire  [isaPkg::WordWidth-1:0]    a,
    input  wire  [isaPkg::WordWidth-1:0]    b,
    input  wire  [ctrlPkg::AluOpWidth-1:0]  aluOp,
    input  wire  [isaPkg::OpcodeWidth-1:0]  opcode,
    output logic [isaPkg::WordWidth-1:0]    result,
    output logic                            branchTaken
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        case (aluOp)
            AluAdd:   result = a + b;
            AluSub:   result = a - b;
            AluAnd:   result = a & b;
            AluOr:    result = a | b;
            AluNot:   result = ~a;
            AluTcp:   result = -a;
            AluShl:   result = a << 1;
            // Arithmetic shift keeps the sign bit
            AluShr:   result = {a[WordWidth-1], a[WordWidth-1:1]};
            AluPassA: result = a;
            AluLhi:   result = {b[ImmWidth-1:0], {ImmWidth{1'b0}}};
            default:  result = a + b;
        endcase
    end

    always_comb begin
        case (opcode)
            OpBne:   branchTaken = (a != b);
            OpBeq:   branchTaken = (a == b);
            OpBgz:   branchTaken = !a[WordWidth-1] && (a != '0);
            OpBlz:   branchTaken = a[WordWidth-1];
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  wire isaPkg::instrWord             instr,
    output logic                              regWrite,
    output logic                              memToReg,
    output logic                              memRead,
    output logic                              memWrite,
    output logic                              isBranch,
    output logic                              aluSrcImm,
    output logic [ctrlPkg::AluOpWidth-1:0]    aluOp,
    output logic                              jumpDirect,
    output logic                              jumpReg,
    output logic                              link,
    output logic                              wwd,
    output logic                              halt,
    output logic [isaPkg::RegAddrWidth-1:0]   destReg,
    output logic                              useRs,
    output logic                              useRt
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        regWrite   = 1'b0;
        memToReg   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        isBranch   = 1'b0;
        aluSrcImm  = 1'b0;
        aluOp      = AluAdd;
        jumpDirect = 1'b0;
        jumpReg    = 1'b0;
        link       = 1'b0;
        wwd        = 1'b0;
        halt       = 1'b0;
        destReg    = instr.iType.rt;
        useRs      = 1'b0;
        useRt      = 1'b0;
        case (instr.rType.opcode)
            OpBne, OpBeq: begin
                isBranch = 1'b1;
                useRs    = 1'b1;
                useRt    = 1'b1;
            end
            // Compare rs against zero only
            OpBgz, OpBlz: begin
                isBranch = 1'b1;
                useRs    = 1'b1;
            end
            OpAdi, OpOri: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                useRs     = 1'b1;
                aluOp     = (instr.rType.opcode == OpOri) ? AluOr : AluAdd;
            end
            OpLhi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = AluLhi;
            end
            OpLwd: begin
                regWrite  = 1'b1;
                memToReg  = 1'b1;
                memRead   = 1'b1;
                aluSrcImm = 1'b1;
                useRs     = 1'b1;
            end
            OpSwd: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                useRs     = 1'b1;
                useRt     = 1'b1;
            end
            OpJmp: jumpDirect = 1'b1;
            OpJal: begin
                jumpDirect = 1'b1;
                link       = 1'b1;
                regWrite   = 1'b1;
                destReg    = LinkReg;
            end
            OpRtype: begin
                destReg = instr.rType.rd;
                useRs   = (instr.rType.func != FnHlt);
                case (instr.rType.func)
                    FnAdd, FnSub, FnAnd, FnOrr: begin
                        regWrite = 1'b1;
                        useRt    = 1'b1;
                    end
                    FnNot, FnTcp, FnShl, FnShr: regWrite = 1'b1;
                    FnJpr: jumpReg = 1'b1;
                    FnJrl: begin
                        jumpReg  = 1'b1;
                        link     = 1'b1;
                        regWrite = 1'b1;
                        destReg  = LinkReg;
                    end
                    FnWwd: wwd = 1'b1;
                    FnHlt: halt = 1'b1;
                    default: ;
                endcase
                case (instr.rType.func)
                    FnSub:   aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOrr:   aluOp = AluOr;
                    FnNot:   aluOp = AluNot;
                    FnTcp:   aluOp = AluTcp;
                    FnShl:   aluOp = AluShl;
                    FnShr:   aluOp = AluShr;
                    FnWwd:   aluOp = AluPassA;
                    default: aluOp = AluAdd;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu (
    input  wire                           Clk,
    input  wire                           rstN,
    output logic [isaPkg::WordWidth-1:0]  instrAddr,
    output logic                          instrRead,
    input  wire  [isaPkg::WordWidth-1:0]  instrData,
    output logic [isaPkg::WordWidth-1:0]  dataAddr,
    output logic                          dataRead,
    output logic                          dataWrite,
    output logic [isaPkg::WordWidth-1:0]  dataWdata,
    input  wire  [isaPkg::WordWidth-1:0]  dataRdata,
    output logic [isaPkg::WordWidth-1:0]  outputPort,
    output logic                          outputValid,
    output logic [isaPkg::WordWidth-1:0]  numInst,
    output logic                          halted
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Decode stage instruction and its controls
    instrWord                decInstr;
    logic                    regWrite;
    logic                    memToReg;
    logic                    memRead;
    logic                    memWrite;
    logic                    isBranch;
    logic                    aluSrcImm;
    logic [AluOpWidth-1:0]   aluOp;
    logic                    jumpDirect;
    logic                    jumpReg;
    logic                    link;
    logic                    wwd;
    logic                    halt;
    logic [RegAddrWidth-1:0] destReg;
    logic                    useRs;
    logic                    useRt;

    datapath i_datapath (.*);

    controlUnit i_controlUnit (
        .instr (decInstr),
        .*
    );

endmodule

`default_nettype wire

// File: hw/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    localparam int AluOpWidth = 4;

    localparam logic [AluOpWidth-1:0] AluAdd   = 4'd0;
    localparam logic [AluOpWidth-1:0] AluSub   = 4'd1;
    localparam logic [AluOpWidth-1:0] AluAnd   = 4'd2;
    localparam logic [AluOpWidth-1:0] AluOr    = 4'd3;
    localparam logic [AluOpWidth-1:0] AluNot   = 4'd4;
    localparam logic [AluOpWidth-1:0] AluTcp   = 4'd5;
    localparam logic [AluOpWidth-1:0] AluShl   = 4'd6;
    localparam logic [AluOpWidth-1:0] AluShr   = 4'd7;
    localparam logic [AluOpWidth-1:0] AluPassA = 4'd8;
    localparam logic [AluOpWidth-1:0] AluLhi   = 4'd9;

    // Operand source in execute
    localparam logic [1:0] FwdNone = 2'd0;
    localparam logic [1:0] FwdMem  = 2'd1;
    localparam logic [1:0] FwdWb   = 2'd2;

    localparam logic [1:0] LinkReg = 2'd2;

endpackage

`default_nettype wire

// File: hw/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  wire                              Clk,
    input  wire                              rstN,
    output logic [isaPkg::WordWidth-1:0]     instrAddr,
    output logic                             instrRead,
    input  wire  [isaPkg::WordWidth-1:0]     instrData,
    output logic [isaPkg::WordWidth-1:0]     dataAddr,
    output logic                             dataRead,
    output logic                             dataWrite,
    output logic [isaPkg::WordWidth-1:0]     dataWdata,
    input  wire  [isaPkg::WordWidth-1:0]     dataRdata,
    output isaPkg::instrWord                 decInstr,
    input  wire                              regWrite,
    input  wire                              memToReg,
    input  wire                              memRead,
    input  wire                              memWrite,
    input  wire                              isBranch,
    input  wire                              aluSrcImm,
    input  wire  [ctrlPkg::AluOpWidth-1:0]   aluOp,
    input  wire                              jumpDirect,
    input  wire                              jumpReg,
    input  wire                              link,
    input  wire                              wwd,
    input  wire                              halt,
    input  wire  [isaPkg::RegAddrWidth-1:0]  destReg,
    input  wire                              useRs,
    input  wire                              useRt,
    output logic [isaPkg::WordWidth-1:0]     outputPort,
    output logic                             outputValid,
    output logic [isaPkg::WordWidth-1:0]     numInst,
    output logic                             halted
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [WordWidth-1:0]    pc;
    logic [WordWidth-1:0]    pcNext;
    logic                    fetchStop;
    logic [WordWidth-1:0]    decPc;
    logic                    decBubble;
    logic [WordWidth-1:0]    decImm;
    logic                    decJump;
    logic                    decHalt;
    logic [WordWidth-1:0]    rsData;
    logic [WordWidth-1:0]    rtData;
    logic                    stall;
    logic                    exKill;
    logic                    exBubble;
    logic [WordWidth-1:0]    exPc;
    logic [WordWidth-1:0]    exRsData;
    logic [WordWidth-1:0]    exRtData;
    logic [WordWidth-1:0]    exImm;
    logic [RegAddrWidth-1:0] exRs;
    logic [RegAddrWidth-1:0] exRt;
    logic [RegAddrWidth-1:0] exRd;
    logic [OpcodeWidth-1:0]  exOpcode;
    logic [AluOpWidth-1:0]   exAluOp;
    logic                    exRegWrite;
    logic                    exMemToReg;
    logic                    exMemRead;
    logic                    exMemWrite;
    logic                    exIsBranch;
    logic                    exAluSrcImm;
    logic                    exJumpReg;
    logic                    exLink;
    logic                    exWwd;
    logic                    exHalt;
    logic [1:0]              forwardA;
    logic [1:0]              forwardB;
    logic [WordWidth-1:0]    fwdA;
    logic [WordWidth-1:0]    fwdB;
    logic [WordWidth-1:0]    aluB;
    logic [WordWidth-1:0]    aluResult;
    logic                    branchTaken;
    logic [WordWidth-1:0]    exLinkAddr;
    logic [WordWidth-1:0]    exResult;
    logic                    exRedirect;
    logic [WordWidth-1:0]    exTarget;
    logic                    memBubble;
    logic [WordWidth-1:0]    memResult;
    logic [WordWidth-1:0]    memStoreData;
    logic [RegAddrWidth-1:0] memRd;
    logic                    memRegWrite;
    logic                    memMemToReg;
    logic                    memMemRead;
    logic                    memMemWrite;
    logic                    memWwd;
    logic                    memHalt;
    logic                    wbBubble;
    logic [WordWidth-1:0]    wbData;
    logic [RegAddrWidth-1:0] wbRd;
    logic                    wbRegWrite;
    logic                    wbWwd;
    logic                    wbHalt;

    function automatic logic [WordWidth-1:0] pickOperand(
        input logic [1:0]           sel,
        input logic [WordWidth-1:0] regVal,
        input logic [WordWidth-1:0] memVal,
        input logic [WordWidth-1:0] wbVal
    );
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign instrAddr = pc;
    assign instrRead = !fetchStop;

    // Decode
    assign decImm  = {{(WordWidth - ImmWidth){decInstr.iType.imm[ImmWidth-1]}}, decInstr.iType.imm};
    assign decJump = !decBubble && jumpDirect && !exRedirect;
    assign decHalt = !decBubble && halt && !exRedirect;
    assign exKill  = stall || exRedirect || decBubble;

    regFile i_regFile (
        .Clk       (Clk),
        .rstN      (rstN),
        .rs        (decInstr.rType.rs),
        .rt        (decInstr.rType.rt),
        .rsData    (rsData),
        .rtData    (rtData),
        .writeEn   (wbRegWrite),
        .writeAddr (wbRd),
        .writeData (wbData)
    );

    hazardUnit i_hazardUnit (
        .decRs       (decInstr.rType.rs),
        .decRt       (decInstr.rType.rt),
        .decUseRs    (useRs && !decBubble),
        .decUseRt    (useRt && !decBubble),
        .exMemRead   (exMemRead),
        .exRd        (exRd),
        .exRs        (exRs),
        .exRt        (exRt),
        .memRegWrite (memRegWrite),
        .memRd       (memRd),
        .wbRegWrite  (wbRegWrite),
        .wbRd        (wbRd),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .stall       (stall)
    );

    // Execute
    assign fwdA       = pickOperand(forwardA, exRsData, memResult, wbData);
    assign fwdB       = pickOperand(forwardB, exRtData, memResult, wbData);
    assign aluB       = exAluSrcImm ? exImm : fwdB;
    assign exLinkAddr = exPc + WordWidth'(1);
    assign exResult   = exLink ? exLinkAddr : aluResult;
    assign exRedirect = (exIsBranch && branchTaken) || exJumpReg;
    assign exTarget   = exJumpReg ? fwdA : exLinkAddr + exImm;

    alu i_alu (
        .a           (fwdA),
        .b           (aluB),
        .aluOp       (exAluOp),
        .opcode      (exOpcode),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    always_comb begin
        if (stall || fetchStop || decHalt)
            pcNext = pc;
        else if (exRedirect)
            pcNext = exTarget;
        else if (decJump)
            pcNext = {pc[WordWidth-1:TargetWidth], decInstr.jType.target};
        else
            pcNext = pc + WordWidth'(1);
    end

    assign dataAddr    = memResult;
    assign dataRead    = memMemRead;
    assign dataWrite   = memMemWrite;
    assign dataWdata   = memStoreData;
    assign outputPort  = wbData;
    assign outputValid = wbWwd;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc          <= '0;
            fetchStop   <= 1'b0;
            halted      <= 1'b0;
            numInst     <= '0;
            decBubble   <= 1'b1;
            exBubble    <= 1'b1;
            exRegWrite  <= 1'b0;
            exMemRead   <= 1'b0;
            exMemWrite  <= 1'b0;
            exIsBranch  <= 1'b0;
            exJumpReg   <= 1'b0;
            exWwd       <= 1'b0;
            exHalt      <= 1'b0;
            memBubble   <= 1'b1;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memWwd      <= 1'b0;
            memHalt     <= 1'b0;
            wbBubble    <= 1'b1;
            wbRegWrite  <= 1'b0;
            wbWwd       <= 1'b0;
            wbHalt      <= 1'b0;
        end else begin
            pc <= pcNext;
            if (decHalt)
                fetchStop <= 1'b1;
            if (wbHalt)
                halted <= 1'b1;
            if (!wbBubble && !wbHalt)
                numInst <= numInst + WordWidth'(1);
            // Stalled decode keeps its instruction
            if (!stall)
                decBubble <= fetchStop || decHalt || decJump || exRedirect;
            exBubble    <= exKill;
            exRegWrite  <= regWrite && !exKill;
            exMemRead   <= memRead && !exKill;
            exMemWrite  <= memWrite && !exKill;
            exIsBranch  <= isBranch && !exKill;
            exJumpReg   <= jumpReg && !exKill;
            exWwd       <= wwd && !exKill;
            exHalt      <= halt && !exKill;
            memBubble   <= exBubble;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memWwd      <= exWwd;
            memHalt     <= exHalt;
            wbBubble    <= memBubble;
            wbRegWrite  <= memRegWrite;
            wbWwd       <= memWwd;
            wbHalt      <= memHalt;
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            decInstr <= instrData;
            decPc    <= pc;
        end
        exPc         <= decPc;
        exRsData     <= rsData;
        exRtData     <= rtData;
        exImm        <= decImm;
        exRs         <= decInstr.rType.rs;
        exRt         <= decInstr.rType.rt;
        exRd         <= destReg;
        exOpcode     <= decInstr.rType.opcode;
        exAluOp      <= aluOp;
        exAluSrcImm  <= aluSrcImm;
        exLink       <= link;
        exMemToReg   <= memToReg;
        memResult    <= exResult;
        memStoreData <= fwdB;
        memRd        <= exRd;
        memMemToReg  <= exMemToReg;
        wbData       <= memMemToReg ? dataRdata : memResult;
        wbRd         <= memRd;
    end

    assert property (@(posedge Clk) disable iff (!rstN) !(dataRead && dataWrite));

    // Fetch must be off well before HLT retires
    assert property (@(posedge Clk) disable iff (!rstN) halted |-> !instrRead);

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  wire  [isaPkg::RegAddrWidth-1:0] decRs,
    input  wire  [isaPkg::RegAddrWidth-1:0] decRt,
    input  wire                             decUseRs,
    input  wire                             decUseRt,
    input  wire                             exMemRead,
    input  wire  [isaPkg::RegAddrWidth-1:0] exRd,
    input  wire  [isaPkg::RegAddrWidth-1:0] exRs,
    input  wire  [isaPkg::RegAddrWidth-1:0] exRt,
    input  wire                             memRegWrite,
    input  wire  [isaPkg::RegAddrWidth-1:0] memRd,
    input  wire                             wbRegWrite,
    input  wire  [isaPkg::RegAddrWidth-1:0] wbRd,
    output logic [1:0]                      forwardA,
    output logic [1:0]                      forwardB,
    output logic                            stall
);
    import ctrlPkg::*;

    // Memory stage holds the younger value
    always_comb begin
        if (memRegWrite && memRd == exRs)
            forwardA = FwdMem;
        else if (wbRegWrite && wbRd == exRs)
            forwardA = FwdWb;
        else
            forwardA = FwdNone;
        if (memRegWrite && memRd == exRt)
            forwardB = FwdMem;
        else if (wbRegWrite && wbRd == exRt)
            forwardB = FwdWb;
        else
            forwardB = FwdNone;
    end

    // Load data only exists after the memory stage
    assign stall = exMemRead && ((decUseRs && decRs == exRd) || (decUseRt && decRt == exRd));

endmodule

`default_nettype wire

// File: hw/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int WordWidth    = 16;
    localparam int RegAddrWidth = 2;
    localparam int NumRegs      = 4;
    localparam int OpcodeWidth  = 4;
    localparam int ImmWidth     = 8;
    localparam int TargetWidth  = 12;

    localparam logic [OpcodeWidth-1:0] OpBne   = 4'd0;
    localparam logic [OpcodeWidth-1:0] OpBeq   = 4'd1;
    localparam logic [OpcodeWidth-1:0] OpBgz   = 4'd2;
    localparam logic [OpcodeWidth-1:0] OpBlz   = 4'd3;
    localparam logic [OpcodeWidth-1:0] OpAdi   = 4'd4;
    localparam logic [OpcodeWidth-1:0] OpOri   = 4'd5;
    localparam logic [OpcodeWidth-1:0] OpLhi   = 4'd6;
    localparam logic [OpcodeWidth-1:0] OpLwd   = 4'd7;
    localparam logic [OpcodeWidth-1:0] OpSwd   = 4'd8;
    localparam logic [OpcodeWidth-1:0] OpJmp   = 4'd9;
    localparam logic [OpcodeWidth-1:0] OpJal   = 4'd10;
    localparam logic [OpcodeWidth-1:0] OpRtype = 4'd15;

    // Function codes under OpRtype
    localparam logic [5:0] FnAdd = 6'd0;
    localparam logic [5:0] FnSub = 6'd1;
    localparam logic [5:0] FnAnd = 6'd2;
    localparam logic [5:0] FnOrr = 6'd3;
    localparam logic [5:0] FnNot = 6'd4;
    localparam logic [5:0] FnTcp = 6'd5;
    localparam logic [5:0] FnShl = 6'd6;
    localparam logic [5:0] FnShr = 6'd7;
    localparam logic [5:0] FnJpr = 6'd25;
    localparam logic [5:0] FnJrl = 6'd26;
    localparam logic [5:0] FnWwd = 6'd28;
    localparam logic [5:0] FnHlt = 6'd29;

    typedef union packed {
        struct packed {
            logic [OpcodeWidth-1:0]  opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [5:0]              func;
        } rType;
        struct packed {
            logic [OpcodeWidth-1:0]  opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [ImmWidth-1:0]     imm;
        } iType;
        struct packed {
            logic [OpcodeWidth-1:0] opcode;
            logic [TargetWidth-1:0] target;
        } jType;
    } instrWord;

endpackage

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  wire                              Clk,
    input  wire                              rstN,
    input  wire  [isaPkg::RegAddrWidth-1:0]  rs,
    input  wire  [isaPkg::RegAddrWidth-1:0]  rt,
    output logic [isaPkg::WordWidth-1:0]     rsData,
    output logic [isaPkg::WordWidth-1:0]     rtData,
    input  wire                              writeEn,
    input  wire  [isaPkg::RegAddrWidth-1:0]  writeAddr,
    input  wire  [isaPkg::WordWidth-1:0]     writeData
);
    import isaPkg::*;

    logic [WordWidth-1:0] regs [NumRegs];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Writeback result is visible to decode in the same cycle
    assign rsData = (writeEn && writeAddr == rs) ? writeData : regs[rs];
    assign rtData = (writeEn && writeAddr == rt) ? writeData : regs[rt];

endmodule

`default_nettype wire

// File: tests/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;
    import isaPkg::*;

    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 200;

    logic                 Clk;
    logic                 rstN;
    logic [WordWidth-1:0] instrAddr;
    logic                 instrRead;
    logic [WordWidth-1:0] instrData;
    logic [WordWidth-1:0] dataAddr;
    logic                 dataRead;
    logic                 dataWrite;
    logic [WordWidth-1:0] dataWdata;
    logic [WordWidth-1:0] dataRdata;
    logic [WordWidth-1:0] outputPort;
    logic                 outputValid;
    logic [WordWidth-1:0] numInst;
    logic                 halted;

    logic [WordWidth-1:0] imem [256];
    logic [WordWidth-1:0] dmem [256];
    logic [WordWidth-1:0] expOut [$];
    logic [WordWidth-1:0] gotOut [$];
    int                   progLen;
    int                   pathCount;
    int                   checkCount;
    int                   errCount;

    cpu i_cpu (.*);

    // Both memories read combinationally
    assign instrData = imem[instrAddr[7:0]];
    assign dataRdata = dataRead ? dmem[dataAddr[7:0]] : '0;

    always @(posedge Clk) begin
        if (dataWrite)
            dmem[dataAddr[7:0]] = dataWdata;
        if (rstN && outputValid)
            gotOut.push_back(outputPort);
    end

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    initial begin
        #(NumTests * CyclesPerTest * 10);
        $display("Watchdog expired before all tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [WordWidth-1:0] sext(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [WordWidth-1:0] fillWord(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a ^ 8'h5a, ~a};
    endfunction

    function automatic instrWord rIns(input logic [1:0] rs, input logic [1:0] rt,
                                      input logic [1:0] rd, input logic [5:0] fn);
        instrWord w;
        w.rType.opcode = OpRtype;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        w.rType.rd     = rd;
        w.rType.func   = fn;
        return w;
    endfunction

    function automatic instrWord iIns(input logic [3:0] op, input logic [1:0] rs,
                                      input logic [1:0] rt, input logic [7:0] imm);
        instrWord w;
        w.iType.opcode = op;
        w.iType.rs     = rs;
        w.iType.rt     = rt;
        w.iType.imm    = imm;
        return w;
    endfunction

    function automatic instrWord jIns(input logic [3:0] op, input logic [11:0] target);
        instrWord w;
        w.jType.opcode = op;
        w.jType.target = target;
        return w;
    endfunction

    task automatic checkWord(input string what, input logic [WordWidth-1:0] got,
                             input logic [WordWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic newProgram;
        for (int i = 0; i < 256; i++) begin
            imem[i] = rIns(0, 0, 0, FnHlt);
            dmem[i] = fillWord(i);
        end
        progLen   = 0;
        pathCount = 0;
        expOut.delete();
    endtask

    // onPath marks instructions that retire
    task automatic emit(input instrWord w, input bit onPath);
        imem[progLen] = w;
        progLen++;
        if (onPath)
            pathCount++;
    endtask

    task automatic emitWwd(input logic [1:0] r, input logic [WordWidth-1:0] exp,
                           input bit onPath);
        emit(rIns(r, 0, 0, FnWwd), onPath);
        if (onPath)
            expOut.push_back(exp);
    endtask

    task automatic resetDut;
        @(posedge Clk);
        rstN <= 1'b0;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        gotOut.delete();
    endtask

    task automatic finishRun(input string name);
        while (!halted)
            @(posedge Clk);
        @(negedge Clk);
        checkWord({name, " strobe count"}, WordWidth'(gotOut.size()),
                  WordWidth'(expOut.size()));
        for (int i = 0; i < gotOut.size() && i < expOut.size(); i++)
            checkWord($sformatf("%s output %0d", name, i), gotOut[i], expOut[i]);
        checkWord({name, " numInst"}, numInst, WordWidth'(pathCount));
    endtask

    task automatic resetState;
        newProgram();
        emit(rIns(0, 0, 0, FnHlt), 0);
        resetDut();
        @(negedge Clk);
        checkWord("reset instrAddr", instrAddr, '0);
        checkFlag("reset instrRead", instrRead, 1'b1);
        checkFlag("reset outputValid", outputValid, 1'b0);
        checkFlag("reset dataRead", dataRead, 1'b0);
        checkFlag("reset dataWrite", dataWrite, 1'b0);
        checkWord("reset numInst", numInst, '0);
        checkFlag("reset halted", halted, 1'b0);
        finishRun("reset");
    endtask

    task automatic arithChain;
        logic [WordWidth-1:0] m [4];
        logic [7:0]           a;
        logic [7:0]           b;
        a = 8'($urandom);
        b = 8'($urandom);
        m = '{default: '0};
        newProgram();
        emit(iIns(OpAdi, 0, 1, a), 1);
        m[1] = sext(a);
        emitWwd(1, m[1], 1);
        emit(iIns(OpAdi, 0, 2, b), 1);
        m[2] = sext(b);
        emitWwd(2, m[2], 1);
        emit(rIns(1, 2, 3, FnAdd), 1);
        m[3] = m[1] + m[2];
        emitWwd(3, m[3], 1);
        emit(rIns(3, 1, 3, FnSub), 1);
        m[3] = m[3] - m[1];
        emitWwd(3, m[3], 1);
        emit(rIns(3, 2, 0, FnAnd), 1);
        m[0] = m[3] & m[2];
        emitWwd(0, m[0], 1);
        emit(rIns(0, 1, 0, FnOrr), 1);
        m[0] = m[0] | m[1];
        emitWwd(0, m[0], 1);
        emit(rIns(0, 0, 1, FnNot), 1);
        m[1] = ~m[0];
        emitWwd(1, m[1], 1);
        emit(rIns(1, 0, 1, FnTcp), 1);
        m[1] = -m[1];
        emitWwd(1, m[1], 1);
        emit(rIns(1, 0, 2, FnShl), 1);
        m[2] = m[1] << 1;
        emitWwd(2, m[2], 1);
        emit(rIns(2, 0, 2, FnShr), 1);
        m[2] = {m[2][15], m[2][15:1]};
        emitWwd(2, m[2], 1);
        emit(iIns(OpLhi, 0, 3, a), 1);
        m[3] = {a, 8'h00};
        emitWwd(3, m[3], 1);
        emit(iIns(OpOri, 3, 3, b), 1);
        m[3] = m[3] | sext(b);
        emitWwd(3, m[3], 1);
        emit(rIns(0, 0, 0, FnHlt), 0);
        resetDut();
        finishRun("arith");
    endtask

    task automatic loadStoreUse;
        logic [7:0] x;
        x = 8'($urandom);
        newProgram();
        emit(iIns(OpAdi, 0, 1, x), 1);
        emit(iIns(OpAdi, 0, 2, 8'd16), 1);
        emit(iIns(OpSwd, 2, 1, 8'd3), 1);
        emit(iIns(OpLwd, 2, 3, 8'd3), 1);
        // Immediate use of the loaded value
        emit(rIns(3, 1, 0, FnAdd), 1);
        emitWwd(0, sext(x) + sext(x), 1);
        emit(iIns(OpLwd, 2, 1, 8'd5), 1);
        emitWwd(1, fillWord(21), 1);
        emit(rIns(0, 0, 0, FnHlt), 0);
        resetDut();
        finishRun("loadstore");
        checkWord("stored word", dmem[19], sext(x));
    endtask

    task automatic branchPaths;
        newProgram();
        emit(iIns(OpAdi, 0, 1, 8'd5), 1);
        emit(iIns(OpAdi, 0, 2, 8'hfd), 1);
        emit(iIns(OpBne, 1, 2, 8'd1), 1);
        emitWwd(2, 16'hfffd, 0);
        emitWwd(1, 16'd5, 1);
        emit(iIns(OpBne, 1, 1, 8'd1), 1);
        emitWwd(2, 16'hfffd, 1);
        emit(iIns(OpBeq, 1, 2, 8'd1), 1);
        emitWwd(2, 16'hfffd, 1);
        emit(iIns(OpBgz, 1, 0, 8'd1), 1);
        emitWwd(2, 16'hfffd, 0);
        emitWwd(1, 16'd5, 1);
        emit(iIns(OpBgz, 2, 0, 8'd1), 1);
        emitWwd(2, 16'hfffd, 1);
        emit(iIns(OpBlz, 2, 0, 8'd1), 1);
        emitWwd(1, 16'd5, 0);
        emitWwd(2, 16'hfffd, 1);
        emit(iIns(OpBlz, 1, 0, 8'd1), 1);
        emitWwd(1, 16'd5, 1);
        emit(iIns(OpBeq, 1, 1, 8'd1), 1);
        emitWwd(2, 16'hfffd, 0);
        emitWwd(1, 16'd5, 1);
        emit(jIns(OpJmp, 12'(progLen + 2)), 1);
        emitWwd(2, 16'hfffd, 0);
        emitWwd(1, 16'd5, 1);
        emit(rIns(0, 0, 0, FnHlt), 0);
        resetDut();
        finishRun("branch");
    endtask

    task automatic linkReturn;
        newProgram();
        emit(jIns(OpJal, 12'd3), 1);
        emit(rIns(2, 0, 0, FnWwd), 1);
        emit(jIns(OpJmp, 12'd6), 1);
        emit(rIns(2, 0, 0, FnWwd), 1);
        emit(rIns(2, 0, 0, FnJpr), 1);
        emit(rIns(0, 0, 0, FnWwd), 0);
        emit(iIns(OpAdi, 0, 1, 8'd9), 1);
        emit(rIns(1, 0, 0, FnJrl), 1);
        emit(rIns(1, 0, 0, FnWwd), 0);
        emit(rIns(2, 0, 0, FnWwd), 1);
        emit(rIns(0, 0, 0, FnHlt), 0);
        // Path order is 0 3 4 1 2 6 7 9
        expOut.push_back(16'd1);
        expOut.push_back(16'd1);
        expOut.push_back(16'd8);
        resetDut();
        finishRun("link");
    endtask

    task automatic haltAndCount;
        newProgram();
        emit(iIns(OpAdi, 0, 1, 8'd7), 1);
        emitWwd(1, 16'd7, 1);
        emit(rIns(0, 0, 0, FnHlt), 0);
        emitWwd(1, 16'd7, 0);
        emitWwd(1, 16'd7, 0);
        resetDut();
        finishRun("halt");
        repeat (20) begin
            @(negedge Clk);
            checkFlag("instrRead after halt", instrRead, 1'b0);
            checkFlag("halted held", halted, 1'b1);
        end
        checkWord("strobes after halt", WordWidth'(gotOut.size()), 16'd1);
    endtask

    initial begin
        rstN       <= 1'b0;
        checkCount = 0;
        errCount   = 0;
        void'($urandom(32'h83dcd12e));
        newProgram();
        resetState();
        arithChain();
        loadStoreUse();
        branchPaths();
        linkReturn();
        haltAndCount();
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/controlUnit.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/datapath.sv
hw/cpu.sv
tests/cpuTb.sv
